// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only -Wall --timing
TOP       ?= ooo_backend_tb
FILELIST  ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "All checks passed" $(LOG) || (echo "Simulation did not pass"; exit 1)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: source/be_cfg.svh
`ifndef BE_CFG_SVH
`define BE_CFG_SVH

// Datapath word width
`define BE_XLEN 32

// Architectural register count
`define BE_NUM_AREGS 32

// ROB entries
`define BE_ROB_DEPTH 8

// Multiplier pipeline depth
`define BE_MUL_LATENCY 3

`endif

// File: source/be_ifs.sv
`timescale 1ns/1ps
`default_nettype none

// Dispatch to execute, operands already resolved
interface issue_if;
  import be_pkg::*;

  logic     valid;
  logic     ready;
  alu_op_e  op;
  xlen_t    a;
  xlen_t    b;
  rob_tag_t tag;

  modport producer (output valid, output op, output a, output b, output tag, input ready);
  modport consumer (input valid, input op, input a, input b, input tag, output ready);
endinterface

// ROB allocation plus two operand lookups
interface rob_alloc_if;
  import be_pkg::*;

  logic     alloc_valid;
  areg_t    alloc_rd;
  logic     alloc_ready;
  rob_tag_t alloc_tag;
  rob_tag_t q1_tag;
  rob_tag_t q2_tag;
  logic     q1_done;
  xlen_t    q1_data;
  logic     q2_done;
  xlen_t    q2_data;

  modport dispatch (
    output alloc_valid, output alloc_rd, input alloc_ready, input alloc_tag,
    output q1_tag, output q2_tag,
    input q1_done, input q1_data, input q2_done, input q2_data
  );
  modport rob (
    input alloc_valid, input alloc_rd, output alloc_ready, output alloc_tag,
    input q1_tag, input q2_tag,
    output q1_done, output q1_data, output q2_done, output q2_data
  );
endinterface

interface arf_read_if;
  import be_pkg::*;

  areg_t raddr1;
  areg_t raddr2;
  xlen_t rdata1;
  xlen_t rdata2;

  modport reader (output raddr1, output raddr2, input rdata1, input rdata2);
  modport file (input raddr1, input raddr2, output rdata1, output rdata2);
endinterface

`default_nettype wire

// File: source/be_pkg.sv
`default_nettype none

`include "be_cfg.svh"

package be_pkg;

  typedef logic [`BE_XLEN-1:0] xlen_t;

  typedef logic [$clog2(`BE_NUM_AREGS)-1:0] areg_t;

  typedef logic [$clog2(`BE_ROB_DEPTH)-1:0] rob_tag_t;

  // MUL is the only multi-cycle op
  typedef enum logic [2:0] {
    OP_ADD = 3'd0,
    OP_SUB = 3'd1,
    OP_AND = 3'd2,
    OP_OR  = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } alu_op_e;

endpackage

`default_nettype wire

// File: source/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_cfg.svh"

module commit_stage (
  input  logic           clk_i,
  input  logic           rst_n_i,
  arf_read_if.file       arf,
  input  logic           ret_valid_i,
  input  be_pkg::areg_t  ret_rd_i,
  input  be_pkg::xlen_t  ret_data_i,
  output logic           commit_valid_o,
  output be_pkg::areg_t  commit_rd_o,
  output be_pkg::xlen_t  commit_data_o
);
  import be_pkg::*;

  xlen_t regs_q [`BE_NUM_AREGS];

  // Retiring value wins over the stored one, x0 is hardwired
  function automatic xlen_t read_port(input areg_t addr, input logic wr_en,
                                      input areg_t wr_addr, input xlen_t wr_data,
                                      input xlen_t stored);
    xlen_t val;
    val = stored;
    if (wr_en && (wr_addr == addr)) begin
      val = wr_data;
    end
    if (addr == '0) begin
      val = '0;
    end
    return val;
  endfunction

  assign arf.rdata1 = read_port(arf.raddr1, ret_valid_i, ret_rd_i, ret_data_i,
                                regs_q[arf.raddr1]);
  assign arf.rdata2 = read_port(arf.raddr2, ret_valid_i, ret_rd_i, ret_data_i,
                                regs_q[arf.raddr2]);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `BE_NUM_AREGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (ret_valid_i && (ret_rd_i != '0)) begin
      regs_q[ret_rd_i] <= ret_data_i;
    end
  end

  // Commit report, one cycle behind retirement
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      commit_valid_o <= 1'b0;
    end else begin
      commit_valid_o <= ret_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (ret_valid_i) begin
      commit_rd_o   <= ret_rd_i;
      commit_data_o <= ret_data_i;
    end
  end

endmodule

`default_nettype wire

// File: source/dispatch_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_cfg.svh"

module dispatch_stage (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  logic              instr_valid_i,
  input  be_pkg::alu_op_e   instr_op_i,
  input  be_pkg::areg_t     instr_rd_i,
  input  be_pkg::areg_t     instr_rs1_i,
  input  be_pkg::areg_t     instr_rs2_i,
  input  be_pkg::xlen_t     instr_imm_i,
  input  logic              instr_use_imm_i,
  output logic              instr_ready_o,
  issue_if.producer         issue,
  rob_alloc_if.dispatch     rob,
  arf_read_if.reader        arf,
  input  logic              ret_valid_i,
  input  be_pkg::areg_t     ret_rd_i,
  input  be_pkg::rob_tag_t  ret_tag_i
);
  import be_pkg::*;

  // Pending table, one entry per register
  logic     busy_q  [`BE_NUM_AREGS];
  rob_tag_t owner_q [`BE_NUM_AREGS];

  logic     iss_valid_q;
  alu_op_e  iss_op_q;
  xlen_t    iss_a_q;
  xlen_t    iss_b_q;
  rob_tag_t iss_tag_q;

  logic  busy1;
  logic  busy2;
  logic  src1_ok;
  logic  src2_ok;
  logic  accept;
  xlen_t opnd_a;
  xlen_t opnd_b;

  // ====================
  // Operand gathering
  // ====================
  assign arf.raddr1 = instr_rs1_i;
  assign arf.raddr2 = instr_rs2_i;
  assign rob.q1_tag = owner_q[instr_rs1_i];
  assign rob.q2_tag = owner_q[instr_rs2_i];

  // Register 0 never becomes busy
  assign busy1   = busy_q[instr_rs1_i];
  assign busy2   = busy_q[instr_rs2_i] && !instr_use_imm_i;
  assign src1_ok = !busy1 || rob.q1_done;
  assign src2_ok = !busy2 || rob.q2_done;

  assign opnd_a = busy1 ? rob.q1_data : arf.rdata1;
  assign opnd_b = instr_use_imm_i ? instr_imm_i : (busy2 ? rob.q2_data : arf.rdata2);

  assign instr_ready_o = rob.alloc_ready && src1_ok && src2_ok &&
                         (!iss_valid_q || issue.ready);
  assign accept = instr_valid_i && instr_ready_o;

  assign rob.alloc_valid = accept;
  assign rob.alloc_rd    = instr_rd_i;

  // ====================
  // Issue register
  // ====================
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      iss_valid_q <= 1'b0;
    end else if (!iss_valid_q || issue.ready) begin
      iss_valid_q <= accept;
    end
  end

  // Only loads when the register is free or draining
  always_ff @(posedge clk_i) begin
    if (accept) begin
      iss_op_q  <= instr_op_i;
      iss_a_q   <= opnd_a;
      iss_b_q   <= opnd_b;
      iss_tag_q <= rob.alloc_tag;
    end
  end

  assign issue.valid = iss_valid_q;
  assign issue.op    = iss_op_q;
  assign issue.a     = iss_a_q;
  assign issue.b     = iss_b_q;
  assign issue.tag   = iss_tag_q;

  // ====================
  // Pending table
  // ====================
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < `BE_NUM_AREGS; i++) begin
        busy_q[i] <= 1'b0;
      end
    end else begin
      // Stale tag means a younger writer still owns the register
      if (ret_valid_i && busy_q[ret_rd_i] && (owner_q[ret_rd_i] == ret_tag_i)) begin
        busy_q[ret_rd_i] <= 1'b0;
      end
      if (accept && (instr_rd_i != '0)) begin
        busy_q[instr_rd_i] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && (instr_rd_i != '0)) begin
      owner_q[instr_rd_i] <= rob.alloc_tag;
    end
  end

  // A pending source never points at the entry being allocated
  a_src_not_tail: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    accept |-> (!(busy1 && (rob.q1_tag == rob.alloc_tag)) &&
                !(busy2 && (rob.q2_tag == rob.alloc_tag))));

endmodule

`default_nettype wire

// File: source/exec_pipe.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_cfg.svh"

module exec_pipe (
  input  logic              clk_i,
  input  logic              rst_n_i,
  issue_if.consumer         issue,
  output logic              wb_valid_o,
  output be_pkg::rob_tag_t  wb_tag_o,
  output be_pkg::xlen_t     wb_data_o
);
  import be_pkg::*;

  localparam int unsigned MulLat = `BE_MUL_LATENCY;

  logic     mul_v_q   [MulLat];
  rob_tag_t mul_tag_q [MulLat];
  xlen_t    mul_p_q   [MulLat];

  logic     lg_v_q;
  rob_tag_t lg_tag_q;
  xlen_t    lg_res_q;

  logic  is_mul;
  logic  fire;
  xlen_t lg_res;

  assign is_mul = (issue.op == OP_MUL);

  // A logic op now would land on the multiply leaving the pipe next cycle
  assign issue.ready = is_mul || !mul_v_q[MulLat-2];
  assign fire        = issue.valid && issue.ready;

  always_comb begin
    case (issue.op)
      OP_ADD:  lg_res = issue.a + issue.b;
      OP_SUB:  lg_res = issue.a - issue.b;
      OP_AND:  lg_res = issue.a & issue.b;
      OP_OR:   lg_res = issue.a | issue.b;
      OP_XOR:  lg_res = issue.a ^ issue.b;
      default: lg_res = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      lg_v_q <= 1'b0;
      for (int i = 0; i < MulLat; i++) begin
        mul_v_q[i] <= 1'b0;
      end
    end else begin
      lg_v_q     <= fire && !is_mul;
      mul_v_q[0] <= fire && is_mul;
      for (int i = 1; i < MulLat; i++) begin
        mul_v_q[i] <= mul_v_q[i-1];
      end
    end
  end

  // Low half of the product only
  always_ff @(posedge clk_i) begin
    lg_tag_q     <= issue.tag;
    lg_res_q     <= lg_res;
    mul_tag_q[0] <= issue.tag;
    mul_p_q[0]   <= issue.a * issue.b;
    for (int i = 1; i < MulLat; i++) begin
      mul_tag_q[i] <= mul_tag_q[i-1];
      mul_p_q[i]   <= mul_p_q[i-1];
    end
  end

  assign wb_valid_o = lg_v_q || mul_v_q[MulLat-1];
  assign wb_tag_o   = mul_v_q[MulLat-1] ? mul_tag_q[MulLat-1] : lg_tag_q;
  assign wb_data_o  = mul_v_q[MulLat-1] ? mul_p_q[MulLat-1] : lg_res_q;

  a_single_wb: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(lg_v_q && mul_v_q[MulLat-1]));

endmodule

`default_nettype wire

// File: source/ooo_backend.sv
`timescale 1ns/1ps
`default_nettype none

module ooo_backend (
  input  logic             clk_i,
  input  logic             rst_n_i,
  input  logic             instr_valid_i,
  input  be_pkg::alu_op_e  instr_op_i,
  input  be_pkg::areg_t    instr_rd_i,
  input  be_pkg::areg_t    instr_rs1_i,
  input  be_pkg::areg_t    instr_rs2_i,
  input  be_pkg::xlen_t    instr_imm_i,
  input  logic             instr_use_imm_i,
  output logic             instr_ready_o,
  output logic             commit_valid_o,
  output be_pkg::areg_t    commit_rd_o,
  output be_pkg::xlen_t    commit_data_o
);
  import be_pkg::*;

  issue_if     issue_bus ();
  rob_alloc_if rob_bus ();
  arf_read_if  arf_bus ();

  logic     wb_valid;
  rob_tag_t wb_tag;
  xlen_t    wb_data;

  logic     ret_valid;
  areg_t    ret_rd;
  rob_tag_t ret_tag;
  xlen_t    ret_data;

  // ====================
  // Producer side
  // ====================
  dispatch_stage u_dispatch (
    .clk_i          (clk_i),
    .rst_n_i        (rst_n_i),
    .instr_valid_i  (instr_valid_i),
    .instr_op_i     (instr_op_i),
    .instr_rd_i     (instr_rd_i),
    .instr_rs1_i    (instr_rs1_i),
    .instr_rs2_i    (instr_rs2_i),
    .instr_imm_i    (instr_imm_i),
    .instr_use_imm_i(instr_use_imm_i),
    .instr_ready_o  (instr_ready_o),
    .issue          (issue_bus.producer),
    .rob            (rob_bus.dispatch),
    .arf            (arf_bus.reader),
    .ret_valid_i    (ret_valid),
    .ret_rd_i       (ret_rd),
    .ret_tag_i      (ret_tag)
  );

  exec_pipe u_exec (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .issue     (issue_bus.consumer),
    .wb_valid_o(wb_valid),
    .wb_tag_o  (wb_tag),
    .wb_data_o (wb_data)
  );

  // ====================
  // Buffer and consumer
  // ====================
  reorder_buffer u_rob (
    .clk_i      (clk_i),
    .rst_n_i    (rst_n_i),
    .alloc      (rob_bus.rob),
    .wb_valid_i (wb_valid),
    .wb_tag_i   (wb_tag),
    .wb_data_i  (wb_data),
    .ret_valid_o(ret_valid),
    .ret_rd_o   (ret_rd),
    .ret_tag_o  (ret_tag),
    .ret_data_o (ret_data)
  );

  commit_stage u_commit (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .arf           (arf_bus.file),
    .ret_valid_i   (ret_valid),
    .ret_rd_i      (ret_rd),
    .ret_data_i    (ret_data),
    .commit_valid_o(commit_valid_o),
    .commit_rd_o   (commit_rd_o),
    .commit_data_o (commit_data_o)
  );

endmodule

`default_nettype wire

// File: source/reorder_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_cfg.svh"

module reorder_buffer (
  input  logic              clk_i,
  input  logic              rst_n_i,
  rob_alloc_if.rob          alloc,
  input  logic              wb_valid_i,
  input  be_pkg::rob_tag_t  wb_tag_i,
  input  be_pkg::xlen_t     wb_data_i,
  output logic              ret_valid_o,
  output be_pkg::areg_t     ret_rd_o,
  output be_pkg::rob_tag_t  ret_tag_o,
  output be_pkg::xlen_t     ret_data_o
);
  import be_pkg::*;

  localparam int unsigned Depth = `BE_ROB_DEPTH;
  localparam int unsigned CntW  = $clog2(Depth) + 1;
  localparam logic [CntW-1:0] Full = CntW'(Depth);

  logic  done_q [Depth];
  areg_t rd_q   [Depth];
  xlen_t data_q [Depth];

  rob_tag_t        head_q;
  rob_tag_t        tail_q;
  logic [CntW-1:0] count_q;

  logic     alloc_fire;
  logic     retire;
  rob_tag_t wb_offset;

  assign alloc.alloc_ready = (count_q != Full);
  assign alloc.alloc_tag   = tail_q;
  assign alloc_fire        = alloc.alloc_valid && alloc.alloc_ready;

  // ====================
  // Operand queries
  // ====================
  assign alloc.q1_done = done_q[alloc.q1_tag];
  assign alloc.q1_data = data_q[alloc.q1_tag];
  assign alloc.q2_done = done_q[alloc.q2_tag];
  assign alloc.q2_data = data_q[alloc.q2_tag];

  // Head leaves in the cycle after its result arrived
  assign retire      = (count_q != '0) && done_q[head_q];
  assign ret_valid_o = retire;
  assign ret_rd_o    = rd_q[head_q];
  assign ret_tag_o   = head_q;
  assign ret_data_o  = data_q[head_q];

  // ====================
  // Pointers and status
  // ====================
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      head_q  <= '0;
      tail_q  <= '0;
      count_q <= '0;
      for (int i = 0; i < Depth; i++) begin
        done_q[i] <= 1'b0;
      end
    end else begin
      if (alloc_fire) begin
        done_q[tail_q] <= 1'b0;
        tail_q         <= tail_q + 1'b1;
      end
      if (wb_valid_i) begin
        done_q[wb_tag_i] <= 1'b1;
      end
      if (retire) begin
        head_q <= head_q + 1'b1;
      end
      count_q <= count_q + CntW'(alloc_fire) - CntW'(retire);
    end
  end

  always_ff @(posedge clk_i) begin
    if (alloc_fire) begin
      rd_q[tail_q] <= alloc.alloc_rd;
    end
    if (wb_valid_i) begin
      data_q[wb_tag_i] <= wb_data_i;
    end
  end

  // Distance from head, modulo the buffer size
  assign wb_offset = wb_tag_i - head_q;

  a_wb_live_entry: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    wb_valid_i |-> ((CntW'(wb_offset) < count_q) && !done_q[wb_tag_i]));

  a_no_alloc_full: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    alloc.alloc_valid |-> (count_q != Full));

endmodule

`default_nettype wire

// File: tb.f
+incdir+source
source/be_pkg.sv
source/be_ifs.sv
source/dispatch_stage.sv
source/exec_pipe.sv
source/reorder_buffer.sv
source/commit_stage.sv
source/ooo_backend.sv
tb/ooo_backend_tb.sv

// File: tb/ooo_backend_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "be_cfg.svh"

module ooo_backend_tb;
  import be_pkg::*;

  localparam int NumDirected   = 26;
  localparam int NumRandom     = 400;
  localparam int TimeoutCycles = 20 * (NumDirected + NumRandom) + 200;

  typedef struct packed {
    alu_op_e op;
    areg_t   rd;
    areg_t   rs1;
    areg_t   rs2;
    xlen_t   imm;
    logic    use_imm;
  } instr_t;

  logic    clk;
  logic    rst_n;
  logic    instr_valid;
  alu_op_e instr_op;
  areg_t   instr_rd;
  areg_t   instr_rs1;
  areg_t   instr_rs2;
  xlen_t   instr_imm;
  logic    instr_use_imm;
  logic    instr_ready;
  logic    commit_valid;
  areg_t   commit_rd;
  xlen_t   commit_data;

  instr_t      sent_q [$];
  xlen_t       golden_regs [`BE_NUM_AREGS];
  logic [31:0] rng_state;
  int          commit_count;
  instr_t      exp_ins;
  xlen_t       exp_data;

  ooo_backend i_dut (
    .clk_i          (clk),
    .rst_n_i        (rst_n),
    .instr_valid_i  (instr_valid),
    .instr_op_i     (instr_op),
    .instr_rd_i     (instr_rd),
    .instr_rs1_i    (instr_rs1),
    .instr_rs2_i    (instr_rs2),
    .instr_imm_i    (instr_imm),
    .instr_use_imm_i(instr_use_imm),
    .instr_ready_o  (instr_ready),
    .commit_valid_o (commit_valid),
    .commit_rd_o    (commit_rd),
    .commit_data_o  (commit_data)
  );

  always #2 clk = ~clk;

  // ====================
  // Helpers
  // ====================
  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Golden result in program order, x0 reads as zero
  function automatic xlen_t ref_result(input instr_t ins);
    xlen_t a;
    xlen_t b;
    xlen_t r;
    a = (ins.rs1 == '0) ? '0 : golden_regs[ins.rs1];
    b = ins.use_imm ? ins.imm : ((ins.rs2 == '0) ? '0 : golden_regs[ins.rs2]);
    case (ins.op)
      OP_ADD:  r = a + b;
      OP_SUB:  r = a - b;
      OP_AND:  r = a & b;
      OP_OR:   r = a | b;
      OP_XOR:  r = a ^ b;
      OP_MUL:  r = a * b;
      default: r = '0;
    endcase
    return r;
  endfunction

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("Checks failed");
    $fatal(1);
  endtask

  task automatic check_flag(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_areg(input string name, input areg_t got, input areg_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
    end
  endtask

  task automatic check_data(input string name, input xlen_t got, input xlen_t exp);
    if (got !== exp) begin
      report_failure($sformatf("CHECK FAILED %s: got 0x%08h expected 0x%08h", name, got, exp));
    end
  endtask

  // Called just after a rising edge, returns just after the accepting edge
  task automatic send_instr(input alu_op_e op, input areg_t rd, input areg_t rs1,
                            input areg_t rs2, input xlen_t imm, input logic use_imm);
    instr_t ins;
    ins.op      = op;
    ins.rd      = rd;
    ins.rs1     = rs1;
    ins.rs2     = rs2;
    ins.imm     = imm;
    ins.use_imm = use_imm;
    instr_valid   <= 1'b1;
    instr_op      <= op;
    instr_rd      <= rd;
    instr_rs1     <= rs1;
    instr_rs2     <= rs2;
    instr_imm     <= imm;
    instr_use_imm <= use_imm;
    @(negedge clk);
    while (!instr_ready) begin
      @(negedge clk);
    end
    sent_q.push_back(ins);
    @(posedge clk);
  endtask

  task automatic idle(input int cycles);
    instr_valid <= 1'b0;
    repeat (cycles) @(posedge clk);
  endtask

  task automatic send_random(input logic force_mul);
    logic [31:0] r;
    alu_op_e     op;
    r = next_rand();
    if (force_mul) begin
      op = OP_MUL;
    end else begin
      op = alu_op_e'(3'(r % 32'd6));
    end
    send_instr(op, areg_t'(r[5:3]), areg_t'(r[8:6]), areg_t'(r[11:9]), next_rand(), r[12]);
  endtask

  // ====================
  // Directed sequences
  // ====================
  task automatic run_independent_ops();
    send_instr(OP_ADD, 5'd1, 5'd0, 5'd0, 32'h1234_5678, 1'b1);
    send_instr(OP_ADD, 5'd2, 5'd0, 5'd0, 32'h0f0f_00ff, 1'b1);
    send_instr(OP_SUB, 5'd3, 5'd1, 5'd2, 32'h0, 1'b0);
    send_instr(OP_AND, 5'd20, 5'd1, 5'd0, 32'hff00_ff00, 1'b1);
    send_instr(OP_OR,  5'd21, 5'd2, 5'd0, 32'h8000_0001, 1'b1);
    send_instr(OP_XOR, 5'd22, 5'd1, 5'd0, 32'hdead_beef, 1'b1);
    send_instr(OP_SUB, 5'd23, 5'd0, 5'd0, 32'h0000_0001, 1'b1);
  endtask

  // MULs land behind the younger logic ops
  task automatic run_mul_mix();
    send_instr(OP_MUL, 5'd4, 5'd1, 5'd2, 32'h0, 1'b0);
    send_instr(OP_ADD, 5'd5, 5'd1, 5'd0, 32'h0000_0010, 1'b1);
    send_instr(OP_XOR, 5'd6, 5'd2, 5'd0, 32'h5555_aaaa, 1'b1);
    send_instr(OP_MUL, 5'd7, 5'd2, 5'd0, 32'h0001_0003, 1'b1);
    send_instr(OP_OR,  5'd8, 5'd3, 5'd1, 32'h0, 1'b0);
    send_instr(OP_MUL, 5'd9, 5'd1, 5'd0, 32'hffff_fffd, 1'b1);
    send_instr(OP_AND, 5'd10, 5'd6, 5'd5, 32'h0, 1'b0);
  endtask

  task automatic run_dependency_chain();
    send_instr(OP_ADD, 5'd11, 5'd0, 5'd0, 32'h0000_0003, 1'b1);
    send_instr(OP_MUL, 5'd12, 5'd11, 5'd11, 32'h0, 1'b0);
    send_instr(OP_ADD, 5'd13, 5'd12, 5'd11, 32'h0, 1'b0);
    send_instr(OP_MUL, 5'd14, 5'd13, 5'd0, 32'h0000_0005, 1'b1);
    send_instr(OP_SUB, 5'd15, 5'd14, 5'd12, 32'h0, 1'b0);
    send_instr(OP_XOR, 5'd11, 5'd15, 5'd11, 32'h0, 1'b0);
    send_instr(OP_MUL, 5'd16, 5'd11, 5'd11, 32'h0, 1'b0);
  endtask

  task automatic run_zero_reg();
    send_instr(OP_ADD, 5'd0, 5'd0, 5'd0, 32'h0000_0055, 1'b1);
    send_instr(OP_MUL, 5'd0, 5'd1, 5'd2, 32'h0, 1'b0);
    send_instr(OP_ADD, 5'd17, 5'd0, 5'd0, 32'h0000_0007, 1'b1);
    send_instr(OP_OR,  5'd18, 5'd0, 5'd1, 32'h0, 1'b0);
    send_instr(OP_SUB, 5'd19, 5'd0, 5'd2, 32'h0, 1'b0);
  endtask

  // ====================
  // Commit checker
  // ====================
  always @(negedge clk) begin
    if (rst_n && commit_valid) begin
      if (sent_q.size() == 0) begin
        report_failure("Commit seen with no instruction outstanding");
      end
      exp_ins  = sent_q.pop_front();
      exp_data = ref_result(exp_ins);
      if (exp_ins.rd != '0) begin
        golden_regs[exp_ins.rd] = exp_data;
      end
      check_areg("commit_rd_o", commit_rd, exp_ins.rd);
      check_data("commit_data_o", commit_data, exp_data);
      commit_count++;
    end
  end

  initial begin
    repeat (TimeoutCycles) @(posedge clk);
    report_failure($sformatf("Run timed out after %0d cycles", TimeoutCycles));
  end

  initial begin
    int burst_left;
    int gap;
    logic [31:0] r;
    clk           = 1'b0;
    rst_n         = 1'b0;
    instr_valid   = 1'b0;
    instr_op      = OP_ADD;
    instr_rd      = '0;
    instr_rs1     = '0;
    instr_rs2     = '0;
    instr_imm     = '0;
    instr_use_imm = 1'b0;
    rng_state     = 32'h6b3f1482;
    commit_count  = 0;
    burst_left    = 0;
    for (int i = 0; i < `BE_NUM_AREGS; i++) begin
      golden_regs[i] = '0;
    end

    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check_flag("commit_valid_o", commit_valid, 1'b0);
    check_flag("instr_ready_o", instr_ready, 1'b1);
    @(posedge clk);

    run_independent_ops();
    idle(3);
    run_mul_mix();
    idle(3);
    run_dependency_chain();
    idle(3);
    run_zero_reg();
    idle(3);

    // Random traffic with gaps and MUL bursts
    for (int n = 0; n < NumRandom; n++) begin
      r = next_rand();
      if ((burst_left == 0) && (r[4:0] == 5'd0)) begin
        burst_left = 12;
      end
      if (burst_left > 0) begin
        burst_left--;
        send_random(1'b1);
      end else begin
        send_random(1'b0);
        gap = (r[9:8] == 2'b00) ? int'(r[11:10]) + 1 : 0;
        if (gap > 0) begin
          idle(gap);
        end
      end
    end
    idle(1);

    while (sent_q.size() != 0) begin
      @(posedge clk);
    end
    repeat (20) @(posedge clk);

    if (commit_count == NumDirected + NumRandom) begin
      $display("All checks passed");
      $finish;
    end else begin
      report_failure($sformatf("Commit count %0d does not match %0d instructions",
                               commit_count, NumDirected + NumRandom));
    end
  end

endmodule

`default_nettype wire
